// File: logic/img_pkg.sv
package img_pkg;

    // ------------------------------
    // stream and window
    // ------------------------------
    localparam int PIX_WIDTH     = 8;
    localparam int WINDOW_TAPS   = 3;
    localparam int WINDOW_CENTER = 1;

    // border rules
    localparam logic [1:0] BORDER_CONSTANT    = 2'd0;
    localparam logic [1:0] BORDER_REPLICATE   = 2'd1;
    localparam logic [1:0] BORDER_REFLECT     = 2'd2;
    localparam logic [1:0] BORDER_REFLECT_101 = 2'd3;

    // ------------------------------
    // arithmetic
    // ------------------------------
    localparam int COEF_WIDTH  = 8;
    localparam int SHIFT_WIDTH = 4;
    localparam int ACC_WIDTH   = 18;

    // k1 = 1, k0 = k2 = 0
    localparam logic [WINDOW_TAPS-1:0][COEF_WIDTH-1:0] COEF_IDENTITY =
        {COEF_WIDTH'(0), COEF_WIDTH'(1), COEF_WIDTH'(0)};

    // ------------------------------
    // register port
    // ------------------------------
    localparam int CFG_ADDR_WIDTH = 2;
    localparam int CFG_DATA_WIDTH = 32;

    localparam logic [CFG_ADDR_WIDTH-1:0] REG_BORDER = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] REG_COEF   = 2'd1;
    localparam logic [CFG_ADDR_WIDTH-1:0] REG_FRAMES = 2'd2;

endpackage

// File: logic/img_stream_if.sv
`timescale 1ns/100ps

interface img_stream_if #(
    parameter int TAPS = 1
);
    import img_pkg::*;

    logic                           row_first;
    logic                           row_last;
    logic                           col_first;
    logic                           col_last;
    logic                           de;
    logic                           valid;
    // tap 0 is the left neighbour
    logic [TAPS-1:0][PIX_WIDTH-1:0] data;

    modport src (
        output row_first,
        output row_last,
        output col_first,
        output col_last,
        output de,
        output valid,
        output data
    );

    modport snk (
        input row_first,
        input row_last,
        input col_first,
        input col_last,
        input de,
        input valid,
        input data
    );

endinterface

// File: logic/img_cfg_regs.sv
`timescale 1ns/100ps

module img_cfg_regs (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  logic                                                  cfg_we,
    input  logic [img_pkg::CFG_ADDR_WIDTH-1:0]                    cfg_addr,
    input  logic [img_pkg::CFG_DATA_WIDTH-1:0]                    cfg_wdata,
    input  logic                                                  frame_start,
    input  logic                                                  frame_done,
    output logic [img_pkg::CFG_DATA_WIDTH-1:0]                    cfg_rdata,
    output logic [1:0]                                            border_mode,
    output logic [img_pkg::PIX_WIDTH-1:0]                         border_value,
    output logic [img_pkg::WINDOW_TAPS-1:0][img_pkg::COEF_WIDTH-1:0] coef,
    output logic [img_pkg::SHIFT_WIDTH-1:0]                       shift
);
    import img_pkg::*;

    logic [1:0]                             stg_mode;
    logic [PIX_WIDTH-1:0]                   stg_value;
    logic [WINDOW_TAPS-1:0][COEF_WIDTH-1:0] stg_coef;
    logic [SHIFT_WIDTH-1:0]                 stg_shift;
    logic [CFG_DATA_WIDTH-1:0]              frame_count;

    // software side, staged copies
    always_ff @(posedge clk) begin
        if (reset) begin
            stg_mode  <= BORDER_REPLICATE;
            stg_value <= '0;
            stg_coef  <= COEF_IDENTITY;
            stg_shift <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                REG_BORDER: begin
                    stg_mode  <= cfg_wdata[1:0];
                    stg_value <= cfg_wdata[8 +: PIX_WIDTH];
                end
                REG_COEF: begin
                    stg_coef  <= cfg_wdata[0 +: WINDOW_TAPS*COEF_WIDTH];
                    stg_shift <= cfg_wdata[24 +: SHIFT_WIDTH];
                end
                default: ;
            endcase
        end
    end

    // active set follows staged only on a frame start
    always_ff @(posedge clk) begin
        if (reset) begin
            border_mode  <= BORDER_REPLICATE;
            border_value <= '0;
            coef         <= COEF_IDENTITY;
            shift        <= '0;
        end else if (frame_start) begin
            border_mode  <= stg_mode;
            border_value <= stg_value;
            coef         <= stg_coef;
            shift        <= stg_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            frame_count <= '0;
        end else if (frame_done) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // readback
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            REG_BORDER: begin
                cfg_rdata[1:0]            = stg_mode;
                cfg_rdata[8 +: PIX_WIDTH] = stg_value;
            end
            REG_COEF: begin
                cfg_rdata[0 +: WINDOW_TAPS*COEF_WIDTH] = stg_coef;
                cfg_rdata[24 +: SHIFT_WIDTH]           = stg_shift;
            end
            REG_FRAMES: cfg_rdata = frame_count;
            default:    cfg_rdata = '0;
        endcase
    end

endmodule

// File: logic/img_pixel_buffer.sv
`timescale 1ns/100ps

module img_pixel_buffer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cke,
    input  logic [1:0]                    border_mode,
    input  logic [img_pkg::PIX_WIDTH-1:0] border_value,
    input  logic                          s_row_first,
    input  logic                          s_row_last,
    input  logic                          s_col_first,
    input  logic                          s_col_last,
    input  logic                          s_de,
    input  logic [img_pkg::PIX_WIDTH-1:0] s_data,
    input  logic                          s_valid,
    img_stream_if.src                     m
);
    import img_pkg::*;

    // flag vectors: {row_first, row_last, col_first, col_last, de}
    logic [4:0]                            in_flags;
    logic [1:0][PIX_WIDTH-1:0]             hist;
    logic                                  pend_valid;
    logic [4:0]                            pend_flags;
    logic                                  tail_valid;
    logic [4:0]                            tail_flags;
    logic [1:0][PIX_WIDTH-1:0]             refl;
    logic                                  st0_valid;
    logic [4:0]                            st0_flags;
    logic [WINDOW_TAPS-1:0][PIX_WIDTH-1:0] st0_win;
    logic                                  st0_col_first;
    logic                                  st0_col_last;
    logic                                  st0_frame_start;
    logic [1:0]                            lat_mode;
    logic [PIX_WIDTH-1:0]                  lat_value;
    logic [1:0]                            cur_mode;
    logic [PIX_WIDTH-1:0]                  cur_value;
    logic                                  st1_valid;
    logic [4:0]                            st1_flags;
    logic [WINDOW_TAPS-1:0][PIX_WIDTH-1:0] st1_win;

    assign in_flags = {s_row_first, s_row_last, s_col_first, s_col_last, s_de};

    // ------------------------------
    // stage 0: window assembly
    // ------------------------------
    // a centre waits for its right neighbour; the last column is
    // sent one cycle later from the reflect store
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            tail_valid <= 1'b0;
            st0_valid  <= 1'b0;
            st0_flags  <= '0;
        end else if (cke) begin
            tail_valid <= s_valid & s_col_last;
            st0_valid  <= 1'b0;
            st0_flags  <= '0;
            if (tail_valid) begin
                st0_valid <= 1'b1;
                st0_flags <= tail_flags;
            end else if (s_valid && pend_valid) begin
                st0_valid <= 1'b1;
                st0_flags <= pend_flags;
            end
            if (s_valid) begin
                pend_valid <= !s_col_last;
            end
        end
    end

    // hist[1] is the newest accepted pixel
    always_ff @(posedge clk) begin
        if (cke) begin
            if (s_valid) begin
                hist       <= {s_data, hist[1]};
                pend_flags <= in_flags;
            end
            if (s_valid && s_col_last) begin
                tail_flags <= in_flags;
                refl       <= {s_data, hist[1]};
            end
            st0_win <= tail_valid ? {refl[1], refl} : {s_data, hist};
        end
    end

    assign st0_col_first   = st0_flags[2];
    assign st0_col_last    = st0_flags[1];
    assign st0_frame_start = st0_valid & st0_flags[4] & st0_col_first;

    // ------------------------------
    // stage 1: border extension
    // ------------------------------
    always_comb begin
        if (st0_frame_start) begin
            cur_mode  = border_mode;
            cur_value = border_value;
        end else begin
            cur_mode  = lat_mode;
            cur_value = lat_value;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
            st1_flags <= '0;
            lat_mode  <= BORDER_REPLICATE;
            lat_value <= '0;
        end else if (cke) begin
            st1_valid <= st0_valid;
            st1_flags <= st0_flags;
            lat_mode  <= cur_mode;
            lat_value <= cur_value;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            st1_win <= st0_win;
            // left edge
            if (st0_col_first) begin
                case (cur_mode)
                    BORDER_CONSTANT:                  st1_win[0] <= cur_value;
                    BORDER_REPLICATE, BORDER_REFLECT: st1_win[0] <= st0_win[WINDOW_CENTER];
                    BORDER_REFLECT_101:               st1_win[0] <= st0_win[WINDOW_TAPS-1];
                endcase
            end
            // right edge, mirror of the left
            if (st0_col_last) begin
                case (cur_mode)
                    BORDER_CONSTANT:    st1_win[WINDOW_TAPS-1] <= cur_value;
                    BORDER_REPLICATE,
                    BORDER_REFLECT:     st1_win[WINDOW_TAPS-1] <= st0_win[WINDOW_CENTER];
                    BORDER_REFLECT_101: st1_win[WINDOW_TAPS-1] <= st0_win[0];
                endcase
            end
        end
    end

    assign {m.row_first, m.row_last, m.col_first, m.col_last, m.de} = st1_flags;
    assign m.data  = st1_win;
    assign m.valid = st1_valid;

endmodule

// File: logic/img_fir3.sv
`timescale 1ns/100ps

module img_fir3 (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    cke,
    input  logic [img_pkg::WINDOW_TAPS-1:0][img_pkg::COEF_WIDTH-1:0] coef,
    input  logic [img_pkg::SHIFT_WIDTH-1:0]                         shift,
    img_stream_if.snk                                               s,
    output logic                                                    m_row_first,
    output logic                                                    m_row_last,
    output logic                                                    m_col_first,
    output logic                                                    m_col_last,
    output logic                                                    m_de,
    output logic [img_pkg::PIX_WIDTH-1:0]                           m_data,
    output logic                                                    m_valid
);
    import img_pkg::*;

    logic                                   frame_start;
    logic [WINDOW_TAPS-1:0][COEF_WIDTH-1:0] cur_coef;
    logic [WINDOW_TAPS-1:0][COEF_WIDTH-1:0] lat_coef;
    logic [SHIFT_WIDTH-1:0]                 cur_shift;
    logic [SHIFT_WIDTH-1:0]                 lat_shift;
    logic signed [ACC_WIDTH-1:0]            prod [WINDOW_TAPS];
    logic signed [ACC_WIDTH-1:0]            sum;
    logic                                   st1_valid;
    logic [4:0]                             st1_flags;
    logic signed [ACC_WIDTH-1:0]            st1_acc;
    logic signed [ACC_WIDTH-1:0]            shifted;
    logic [PIX_WIDTH-1:0]                   clamped;
    logic [4:0]                             st2_flags;

    // new frame picks up the active settings directly
    assign frame_start = s.valid & s.row_first & s.col_first;
    assign cur_coef    = frame_start ? coef : lat_coef;
    assign cur_shift   = frame_start ? shift : lat_shift;

    // ------------------------------
    // stage 1: products and sum
    // ------------------------------
    always_comb begin
        sum = '0;
        for (int i = 0; i < WINDOW_TAPS; i++) begin
            prod[i] = $signed({1'b0, s.data[i]}) * $signed(cur_coef[i]);
            sum     = sum + prod[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
            st1_flags <= '0;
            lat_coef  <= COEF_IDENTITY;
            lat_shift <= '0;
        end else if (cke) begin
            st1_valid <= s.valid;
            st1_flags <= {s.row_first, s.row_last, s.col_first, s.col_last, s.de};
            lat_coef  <= cur_coef;
            lat_shift <= cur_shift;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            st1_acc <= sum;
        end
    end

    // ------------------------------
    // stage 2: shift and clamp
    // ------------------------------
    always_comb begin
        shifted = st1_acc >>> lat_shift;
        if (shifted < 0) begin
            clamped = '0;
        end else if (shifted > (2 ** PIX_WIDTH) - 1) begin
            clamped = '1;
        end else begin
            clamped = shifted[PIX_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            m_valid   <= 1'b0;
            st2_flags <= '0;
        end else if (cke) begin
            m_valid   <= st1_valid;
            st2_flags <= st1_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (cke) begin
            m_data <= clamped;
        end
    end

    assign {m_row_first, m_row_last, m_col_first, m_col_last, m_de} = st2_flags;

endmodule

// File: logic/img_hfilter_top.sv
`timescale 1ns/100ps

module img_hfilter_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               s_row_first,
    input  logic                               s_row_last,
    input  logic                               s_col_first,
    input  logic                               s_col_last,
    input  logic                               s_de,
    input  logic [img_pkg::PIX_WIDTH-1:0]      s_data,
    input  logic                               s_valid,
    output logic                               s_ready,
    output logic                               m_row_first,
    output logic                               m_row_last,
    output logic                               m_col_first,
    output logic                               m_col_last,
    output logic                               m_de,
    output logic [img_pkg::PIX_WIDTH-1:0]      m_data,
    output logic                               m_valid,
    input  logic                               m_ready,
    input  logic                               cfg_we,
    input  logic [img_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [img_pkg::CFG_DATA_WIDTH-1:0] cfg_wdata,
    output logic [img_pkg::CFG_DATA_WIDTH-1:0] cfg_rdata
);
    import img_pkg::*;

    logic [1:0]                             border_mode;
    logic [PIX_WIDTH-1:0]                   border_value;
    logic [WINDOW_TAPS-1:0][COEF_WIDTH-1:0] coef;
    logic [SHIFT_WIDTH-1:0]                 shift;
    logic                                   frame_start;
    logic                                   frame_done;

    // whole pipeline runs on m_ready
    assign s_ready     = m_ready;
    assign frame_start = s_valid & s_ready & s_row_first & s_col_first;
    assign frame_done  = m_valid & m_ready & m_row_last & m_col_last;

    img_stream_if #(.TAPS(WINDOW_TAPS)) pix_win ();

    img_cfg_regs i_img_cfg_regs (
        .clk          (clk),
        .reset        (reset),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .frame_start  (frame_start),
        .frame_done   (frame_done),
        .cfg_rdata    (cfg_rdata),
        .border_mode  (border_mode),
        .border_value (border_value),
        .coef         (coef),
        .shift        (shift)
    );

    img_pixel_buffer i_img_pixel_buffer (
        .clk          (clk),
        .reset        (reset),
        .cke          (m_ready),
        .border_mode  (border_mode),
        .border_value (border_value),
        .s_row_first  (s_row_first),
        .s_row_last   (s_row_last),
        .s_col_first  (s_col_first),
        .s_col_last   (s_col_last),
        .s_de         (s_de),
        .s_data       (s_data),
        .s_valid      (s_valid),
        .m            (pix_win.src)
    );

    img_fir3 i_img_fir3 (
        .clk         (clk),
        .reset       (reset),
        .cke         (m_ready),
        .coef        (coef),
        .shift       (shift),
        .s           (pix_win.snk),
        .m_row_first (m_row_first),
        .m_row_last  (m_row_last),
        .m_col_first (m_col_first),
        .m_col_last  (m_col_last),
        .m_de        (m_de),
        .m_data      (m_data),
        .m_valid     (m_valid)
    );

endmodule

// File: dv/img_hfilter_chk.sv
`timescale 1ns/100ps

module img_hfilter_chk (
    input logic                          clk,
    input logic                          reset,
    input logic                          s_ready,
    input logic                          m_ready,
    input logic                          m_valid,
    input logic                          m_row_first,
    input logic                          m_row_last,
    input logic                          m_col_first,
    input logic                          m_col_last,
    input logic                          m_de,
    input logic [img_pkg::PIX_WIDTH-1:0] m_data
);

    logic [12:0] out_beat;

    assign out_beat = {m_row_first, m_row_last, m_col_first, m_col_last, m_de, m_data};

    assert property (@(posedge clk) reset |=> !m_valid)
        else $error("m_valid is high right after a reset cycle");

    // stalled output beat must not move
    assert property (@(posedge clk) disable iff (reset)
        (m_valid && !m_ready) |=> (m_valid && $stable(out_beat)))
        else $error("output beat changed while stalled by m_ready");

    assert property (@(posedge clk) s_ready == m_ready)
        else $error("s_ready does not follow m_ready");

endmodule

bind img_hfilter_top img_hfilter_chk i_img_hfilter_chk (
    .clk(clk), .reset(reset), .s_ready(s_ready), .m_ready(m_ready), .m_valid(m_valid),
    .m_row_first(m_row_first), .m_row_last(m_row_last), .m_col_first(m_col_first),
    .m_col_last(m_col_last), .m_de(m_de), .m_data(m_data)
);

// File: dv/img_hfilter_tb.sv
`timescale 1ns/100ps

module img_hfilter_tb;
    import img_pkg::*;

    localparam int MAX_W   = 16;
    localparam int TIMEOUT = 200;

    logic                      clk;
    logic                      reset;
    logic                      s_row_first;
    logic                      s_row_last;
    logic                      s_col_first;
    logic                      s_col_last;
    logic                      s_de;
    logic [PIX_WIDTH-1:0]      s_data;
    logic                      s_valid;
    logic                      s_ready;
    logic                      m_row_first;
    logic                      m_row_last;
    logic                      m_col_first;
    logic                      m_col_last;
    logic                      m_de;
    logic [PIX_WIDTH-1:0]      m_data;
    logic                      m_valid;
    logic                      m_ready;
    logic                      cfg_we;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
    logic [CFG_DATA_WIDTH-1:0] cfg_wdata;
    logic [CFG_DATA_WIDTH-1:0] cfg_rdata;

    logic [31:0] lfsr;
    // register model of the staged and active words
    logic [31:0] stg_border;
    logic [31:0] stg_coef;
    logic [31:0] act_border;
    logic [31:0] act_coef;
    logic [12:0] exp_q[$];
    logic [12:0] got;
    logic [12:0] expected;
    int          frames_sent;
    int          frames_seen;
    int          beats_seen;

    img_hfilter_top i_img_hfilter_top (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] ref_pixel(input logic [7:0] p [MAX_W], input int w,
                                             input int x, input logic [31:0] brd,
                                             input logic [31:0] cf);
        int left;
        int right;
        int acc;
        if (x > 0) begin
            left = int'(p[x-1]);
        end else begin
            case (brd[1:0])
                BORDER_CONSTANT:    left = int'(brd[15:8]);
                BORDER_REFLECT_101: left = int'(p[1]);
                default:            left = int'(p[0]);
            endcase
        end
        if (x < w - 1) begin
            right = int'(p[x+1]);
        end else begin
            case (brd[1:0])
                BORDER_CONSTANT:    right = int'(brd[15:8]);
                BORDER_REFLECT_101: right = int'(p[w-2]);
                default:            right = int'(p[w-1]);
            endcase
        end
        acc = int'($signed(cf[7:0])) * left + int'($signed(cf[15:8])) * int'(p[x])
            + int'($signed(cf[23:16])) * right;
        acc = acc >>> cf[27:24];
        if (acc < 0) begin
            return 8'd0;
        end else if (acc > 255) begin
            return 8'd255;
        end
        return 8'(acc);
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // one clock with a random m_ready drop now and then
    task automatic cycle();
        @(posedge clk);
        cfg_we  <= 1'b0;
        m_ready <= (rand_bits(2) != 0);
    endtask

    task automatic drive_write(input logic [1:0] addr, input logic [31:0] data);
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        if (addr == REG_BORDER) begin
            stg_border = data & 32'h0000_ff03;
        end else if (addr == REG_COEF) begin
            stg_coef = data & 32'h0fff_ffff;
        end
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        cycle();
        drive_write(addr, data);
    endtask

    task automatic cfg_check(input logic [1:0] addr, input logic [31:0] exp);
        cycle();
        cfg_addr <= addr;
        @(negedge clk);
        assert (cfg_rdata == exp) else stop_run($sformatf(
            "ERR %0t: register %0d reads %h, expected %h", $time, addr, cfg_rdata, exp));
    endtask

    task automatic send_frame(input int w, input int h, input bit stripes,
                              input bit mid_wr, input logic [31:0] mid_coef);
        logic [7:0]       pix [MAX_W];
        logic [MAX_W-1:0] de;
        int               tries;
        act_border = stg_border;
        act_coef   = stg_coef;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                pix[x] = stripes ? ((x % 2 == 1) ? 8'hff : 8'h00) : 8'(rand_bits(8));
                de[x]  = (rand_bits(1) != 0);
            end
            for (int x = 0; x < w; x++) begin
                exp_q.push_back({y == 0, y == h - 1, x == 0, x == w - 1, de[x],
                                 ref_pixel(pix, w, x, act_border, act_coef)});
            end
            for (int x = 0; x < w; x++) begin
                repeat (rand_bits(2)) begin
                    cycle();
                    s_valid <= 1'b0;
                end
                cycle();
                s_valid     <= 1'b1;
                s_row_first <= (y == 0);
                s_row_last  <= (y == h - 1);
                s_col_first <= (x == 0);
                s_col_last  <= (x == w - 1);
                s_de        <= de[x];
                s_data      <= pix[x];
                if (mid_wr && y * w + x == (w * h) / 2) begin
                    drive_write(REG_COEF, mid_coef);
                end
                tries = 0;
                @(negedge clk);
                while (!m_ready) begin
                    tries++;
                    if (tries > TIMEOUT) begin
                        stop_run("timeout: input beat was never accepted");
                    end
                    cycle();
                    @(negedge clk);
                end
            end
        end
        frames_sent++;
        // empty beats until every expected beat has come out
        tries = 0;
        while (exp_q.size() != 0) begin
            tries++;
            if (tries > TIMEOUT) begin
                stop_run("timeout: pipeline did not drain the frame");
            end
            cycle();
            s_valid <= 1'b0;
        end
    endtask

    task automatic random_frame();
        int w;
        int h;
        w = 3 + int'(rand_bits(4) % 14);
        h = 1 + int'(rand_bits(2));
        send_frame(w, h, 1'b0, 1'b0, 32'h0);
    endtask

    // ------------------------------
    // output compare
    // ------------------------------
    always @(negedge clk) begin
        if (!reset) begin
            assert (s_ready == m_ready) else stop_run($sformatf(
                "ERR %0t: s_ready %b differs from m_ready %b", $time, s_ready, m_ready));
            if (m_valid && m_ready) begin
                assert (exp_q.size() != 0) else stop_run($sformatf(
                    "ERR %0t: output beat with no input beat left", $time));
                expected = exp_q.pop_front();
                got      = {m_row_first, m_row_last, m_col_first, m_col_last, m_de, m_data};
                assert (got == expected) else stop_run($sformatf(
                    "ERR %0t: output beat %0d is %h, expected %h",
                    $time, beats_seen, got, expected));
                beats_seen++;
                if (m_row_last && m_col_last) begin
                    frames_seen++;
                end
            end
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin
        lfsr        = 32'hdbb93a18;
        frames_sent = 0;
        frames_seen = 0;
        beats_seen  = 0;
        stg_border  = 32'h0000_0001;
        stg_coef    = 32'h0000_0100;
        reset       = 1'b1;
        s_row_first = 1'b0;
        s_row_last  = 1'b0;
        s_col_first = 1'b0;
        s_col_last  = 1'b0;
        s_de        = 1'b0;
        s_data      = '0;
        s_valid     = 1'b0;
        m_ready     = 1'b0;
        cfg_we      = 1'b0;
        cfg_addr    = '0;
        cfg_wdata   = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // identity after reset
        cfg_check(REG_BORDER, 32'h0000_0001);
        cfg_check(REG_COEF, 32'h0000_0100);
        repeat (3) random_frame();

        // 1-2-1 smoothing under each border rule
        for (int m = 0; m < 4; m++) begin
            cfg_write(REG_BORDER, {16'h0, 8'(rand_bits(8)), 6'h0, 2'(m)});
            cfg_write(REG_COEF, 32'h0201_0201);
            cfg_check(REG_BORDER, stg_border);
            repeat (2) random_frame();
        end

        // sharpening clamps at both ends
        cfg_write(REG_COEF, 32'h00ff_04ff);
        send_frame(8, 2, 1'b1, 1'b0, 32'h0);
        repeat (3) random_frame();

        // mid-frame rewrite waits for the next frame
        cfg_write(REG_COEF, 32'h0201_0201);
        send_frame(10, 3, 1'b0, 1'b1, 32'hf101_0101);
        cfg_check(REG_COEF, 32'h0101_0101);
        random_frame();

        cfg_check(REG_FRAMES, 32'(frames_sent));
        assert (frames_seen == frames_sent) else stop_run($sformatf(
            "ERR %0t: %0d frames received, %0d sent", $time, frames_seen, frames_sent));

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: vlog.f
logic/img_pkg.sv
logic/img_stream_if.sv
logic/img_cfg_regs.sv
logic/img_pixel_buffer.sv
logic/img_fir3.sv
logic/img_hfilter_top.sv
dv/img_hfilter_chk.sv
dv/img_hfilter_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = img_hfilter_tb
FILELIST = vlog.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
